/* vlane_macros.svh */
`ifndef VLANE_MACROS_SVH
`define VLANE_MACROS_SVH

// row geometry
`define VL_LANES        4
`define VL_DATA_W       32
`define VL_ROW_W        (`VL_LANES * `VL_DATA_W)

// vector register file
`define VL_REGS         16
`define VL_REG_AW       4   // also the width of the row count field

// external memory, addressed in rows
`define VL_MEM_AW       16
`define VL_MEM_CREDITS  4   // outstanding requests

// input stream buffer, sender starts with this many credits
`define VL_STREAM_DEPTH 8

`endif

/* vlane_isa_pkg.sv */
`default_nettype none

`include "vlane_macros.svh"

package vlane_isa_pkg;

    typedef enum logic [1:0] {
        OP_VLOAD  = 2'd0,
        OP_VSTORE = 2'd1,
        OP_VMACC  = 2'd2
    } opcode_e;

    // memory view used by vload / vstore
    typedef struct packed {
        opcode_e                opcode;
        logic [`VL_REG_AW-1:0]  vreg;     // first register row
        logic [`VL_REG_AW-1:0]  count;    // rows minus one
        logic [`VL_MEM_AW-1:0]  mem_addr; // first memory row
        logic [5:0]             spare;
    } mem_instr_t;

    // arithmetic view used by vmacc
    typedef struct packed {
        opcode_e                opcode;
        logic [`VL_REG_AW-1:0]  vd;       // accumulator rows
        logic [`VL_REG_AW-1:0]  vs;       // multiplier rows
        logic [`VL_REG_AW-1:0]  count;
        logic [17:0]            spare;
    } arith_instr_t;

    typedef union packed {
        mem_instr_t   mem;
        arith_instr_t arith;
    } instr_u;

endpackage

`default_nettype wire

/* vlane_mem_pkg.sv */
`default_nettype none

`include "vlane_macros.svh"

package vlane_mem_pkg;

    // lane 0 sits in the low word
    typedef logic [`VL_LANES-1:0][`VL_DATA_W-1:0] row_t;

    typedef struct packed {
        logic                  we;    // 1 = write row, 0 = read row
        logic [`VL_MEM_AW-1:0] addr;
        row_t                  wdata;
    } mem_req_t;

    typedef struct packed {
        logic                  en;
        logic [`VL_REG_AW-1:0] addr;
        row_t                  data;
    } rf_wr_t;

endpackage

`default_nettype wire

/* stream_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

`include "vlane_macros.svh"

module stream_fifo (
    input  logic                clk,
    input  logic                i_reset,
    input  logic                i_push,
    input  vlane_mem_pkg::row_t i_push_row,
    input  logic                i_pop,
    output vlane_mem_pkg::row_t o_row,
    output logic                o_empty,
    output logic                o_credit
);

    localparam int AW = $clog2(`VL_STREAM_DEPTH);

    vlane_mem_pkg::row_t mem [`VL_STREAM_DEPTH];
    logic [AW-1:0] wr_ptr, rd_ptr;
    logic [AW:0]   fill;

    assign o_row   = mem[rd_ptr];
    assign o_empty = (fill == '0);

    always_ff @(posedge clk) begin
        if (i_push) mem[wr_ptr] <= i_push_row;
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fill     <= '0;
            o_credit <= 1'b0;
        end else begin
            o_credit <= i_pop; // one credit back per row taken
            if (i_push) wr_ptr <= wr_ptr + 1'b1;
            if (i_pop)  rd_ptr <= rd_ptr + 1'b1;
            if (i_push && !i_pop)      fill <= fill + 1'b1;
            else if (!i_push && i_pop) fill <= fill - 1'b1;
        end
    end

    // sender credit accounting must keep the buffer from overflowing
    a_no_overrun: assert property (@(posedge clk) disable iff (i_reset)
        (fill == `VL_STREAM_DEPTH) |-> !i_push);

endmodule

`default_nettype wire

/* vector_regfile.sv */
`timescale 1ns/10ps
`default_nettype none

`include "vlane_macros.svh"

module vector_regfile (
    input  logic                   clk,
    input  logic [`VL_REG_AW-1:0]  i_raddr_a,
    input  logic [`VL_REG_AW-1:0]  i_raddr_b,
    input  logic [`VL_REG_AW-1:0]  i_raddr_c,
    input  vlane_mem_pkg::rf_wr_t  i_wr_load,
    input  vlane_mem_pkg::rf_wr_t  i_wr_mac,
    output vlane_mem_pkg::row_t    o_rdata_a,
    output vlane_mem_pkg::row_t    o_rdata_b,
    output vlane_mem_pkg::row_t    o_rdata_c
);

    vlane_mem_pkg::row_t   rows [`VL_REGS];
    vlane_mem_pkg::rf_wr_t wr;

    // load engine wins, the two never overlap in practice
    assign wr = i_wr_load.en ? i_wr_load : i_wr_mac;

    always_ff @(posedge clk) begin
        if (wr.en) rows[wr.addr] <= wr.data;
    end

    assign o_rdata_a = rows[i_raddr_a];
    assign o_rdata_b = rows[i_raddr_b];
    assign o_rdata_c = rows[i_raddr_c]; // store path

    // only one engine runs per instruction
    // write enables are unknown until the engines see their first reset edge
    a_single_writer: assert property (@(posedge clk)
        !(i_wr_load.en === 1'b1 && i_wr_mac.en === 1'b1));

endmodule

`default_nettype wire

/* vlane_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "vlane_macros.svh"

module vlane_sequencer (
    input  logic                   clk,
    input  logic                   i_reset,
    input  logic                   i_instr_valid,
    input  vlane_isa_pkg::instr_u  i_instr,
    input  logic                   i_load_done,
    input  logic                   i_store_done,
    input  logic                   i_mac_done,
    output logic                   o_instr_credit,
    output logic                   o_load_start,
    output logic                   o_store_start,
    output logic                   o_mac_start,
    output logic [`VL_REG_AW-1:0]  o_vreg,
    output logic [`VL_REG_AW-1:0]  o_vs,
    output logic [`VL_MEM_AW-1:0]  o_mem_addr,
    output logic [`VL_REG_AW-1:0]  o_count
);

    vlane_isa_pkg::opcode_e op_q, op_in;
    logic busy, accept, done_hit;

    assign op_in  = i_instr.mem.opcode; // opcode sits at the same bits in both views
    assign accept = i_instr_valid && !busy;

    always_comb begin
        case (op_q)
            vlane_isa_pkg::OP_VLOAD:  done_hit = i_load_done;
            vlane_isa_pkg::OP_VSTORE: done_hit = i_store_done;
            vlane_isa_pkg::OP_VMACC:  done_hit = i_mac_done;
            default:                  done_hit = 1'b1; // unused encoding retires at once
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            busy           <= 1'b0;
            op_q           <= vlane_isa_pkg::OP_VLOAD;
            o_instr_credit <= 1'b0;
            o_load_start   <= 1'b0;
            o_store_start  <= 1'b0;
            o_mac_start    <= 1'b0;
        end else begin
            o_instr_credit <= busy && done_hit;
            o_load_start   <= accept && (op_in == vlane_isa_pkg::OP_VLOAD);
            o_store_start  <= accept && (op_in == vlane_isa_pkg::OP_VSTORE);
            o_mac_start    <= accept && (op_in == vlane_isa_pkg::OP_VMACC);
            if (accept) begin
                busy <= 1'b1;
                op_q <= op_in;
            end else if (busy && done_hit) begin
                busy <= 1'b0;
            end
        end
    end

    // fields stay put until the next instruction
    always_ff @(posedge clk) begin
        if (accept) begin
            if (op_in == vlane_isa_pkg::OP_VMACC) begin
                o_vreg  <= i_instr.arith.vd;
                o_vs    <= i_instr.arith.vs;
                o_count <= i_instr.arith.count;
            end else begin
                o_vreg     <= i_instr.mem.vreg;
                o_count    <= i_instr.mem.count;
                o_mem_addr <= i_instr.mem.mem_addr;
            end
        end
    end

    // sender holds a single credit
    a_one_in_flight: assert property (@(posedge clk) disable iff (i_reset)
        i_instr_valid |-> !busy);

endmodule

`default_nettype wire

/* vmacc_unit.sv */
`timescale 1ns/10ps
`default_nettype none

`include "vlane_macros.svh"

module vmacc_unit (
    input  logic                   clk,
    input  logic                   i_reset,
    input  logic                   i_start,
    input  logic [`VL_REG_AW-1:0]  i_vd,
    input  logic [`VL_REG_AW-1:0]  i_vs,
    input  logic [`VL_REG_AW-1:0]  i_count,
    input  logic                   i_fifo_empty,
    input  vlane_mem_pkg::row_t    i_stream_row,
    input  vlane_mem_pkg::row_t    i_rs_row,
    input  vlane_mem_pkg::row_t    i_rd_row,
    output logic                   o_pop,
    output logic [`VL_REG_AW-1:0]  o_rs_addr,
    output logic [`VL_REG_AW-1:0]  o_rd_addr,
    output vlane_mem_pkg::rf_wr_t  o_wr,
    output logic                   o_done
);

    logic                  active, wr_en_q;
    logic [`VL_REG_AW-1:0] idx, wr_addr_q;
    vlane_mem_pkg::row_t   wr_data_q;

    assign o_pop     = active && !i_fifo_empty; // stall on empty stream
    assign o_rs_addr = i_vs + idx;
    assign o_rd_addr = i_vd + idx;
    assign o_wr      = '{en: wr_en_q, addr: wr_addr_q, data: wr_data_q};

    always_ff @(posedge clk) begin
        if (i_reset) begin
            active  <= 1'b0;
            idx     <= '0;
            wr_en_q <= 1'b0;
            o_done  <= 1'b0;
        end else begin
            wr_en_q <= o_pop;
            o_done  <= o_pop && (idx == i_count); // lands with the last write
            if (i_start) begin
                active <= 1'b1;
                idx    <= '0;
            end else if (o_pop) begin
                idx <= idx + 1'b1;
                if (idx == i_count) active <= 1'b0;
            end
        end
    end

    // vd += stream * vs, low 32 bits per lane
    always_ff @(posedge clk) begin
        if (o_pop) begin
            wr_addr_q <= o_rd_addr;
            for (int l = 0; l < `VL_LANES; l++)
                wr_data_q[l] <= i_rd_row[l] + i_stream_row[l] * i_rs_row[l];
        end
    end

endmodule

`default_nettype wire

/* mem_load_engine.sv */
`timescale 1ns/10ps
`default_nettype none

`include "vlane_macros.svh"

module mem_load_engine (
    input  logic                   clk,
    input  logic                   i_reset,
    input  logic                   i_start,
    input  logic [`VL_REG_AW-1:0]  i_vreg,
    input  logic [`VL_MEM_AW-1:0]  i_mem_addr,
    input  logic [`VL_REG_AW-1:0]  i_count,
    input  logic                   i_grant,
    input  logic                   i_rsp_valid,
    input  vlane_mem_pkg::row_t    i_rsp_data,
    output logic                   o_req,
    output logic [`VL_MEM_AW-1:0]  o_req_addr,
    output vlane_mem_pkg::rf_wr_t  o_wr,
    output logic                   o_done
);

    logic                  issuing, active, wr_en_q;
    logic [`VL_REG_AW-1:0] iss, rsp, wr_addr_q;
    vlane_mem_pkg::row_t   wr_data_q;
    logic                  take;

    assign o_req      = issuing;
    assign o_req_addr = i_mem_addr + `VL_MEM_AW'(iss);
    assign take       = active && i_rsp_valid; // responses come back in order
    assign o_wr       = '{en: wr_en_q, addr: wr_addr_q, data: wr_data_q};

    always_ff @(posedge clk) begin
        if (i_reset) begin
            issuing <= 1'b0;
            active  <= 1'b0;
            iss     <= '0;
            rsp     <= '0;
            wr_en_q <= 1'b0;
            o_done  <= 1'b0;
        end else begin
            wr_en_q <= take;
            o_done  <= take && (rsp == i_count);
            if (i_start) begin
                issuing <= 1'b1;
                active  <= 1'b1;
                iss     <= '0;
                rsp     <= '0;
            end else begin
                if (o_req && i_grant) begin
                    iss <= iss + 1'b1;
                    if (iss == i_count) issuing <= 1'b0;
                end
                if (take) begin
                    rsp <= rsp + 1'b1;
                    if (rsp == i_count) active <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            wr_addr_q <= i_vreg + rsp;
            wr_data_q <= i_rsp_data;
        end
    end

endmodule

`default_nettype wire

/* mem_store_engine.sv */
`timescale 1ns/10ps
`default_nettype none

`include "vlane_macros.svh"

module mem_store_engine (
    input  logic                   clk,
    input  logic                   i_reset,
    input  logic                   i_start,
    input  logic [`VL_REG_AW-1:0]  i_vreg,
    input  logic [`VL_MEM_AW-1:0]  i_mem_addr,
    input  logic [`VL_REG_AW-1:0]  i_count,
    input  logic                   i_grant,
    input  vlane_mem_pkg::row_t    i_row,
    output logic                   o_req,
    output logic [`VL_MEM_AW-1:0]  o_req_addr,
    output logic [`VL_REG_AW-1:0]  o_raddr,
    output logic                   o_done
);

    logic                  active;
    logic [`VL_REG_AW-1:0] idx;

    // register row read combinationally, sent in the same cycle
    assign o_req      = active;
    assign o_raddr    = i_vreg + idx;
    assign o_req_addr = i_mem_addr + `VL_MEM_AW'(idx);

    always_ff @(posedge clk) begin
        if (i_reset) begin
            active <= 1'b0;
            idx    <= '0;
            o_done <= 1'b0;
        end else begin
            o_done <= active && i_grant && (idx == i_count);
            if (i_start) begin
                active <= 1'b1;
                idx    <= '0;
            end else if (active && i_grant) begin
                idx <= idx + 1'b1;
                if (idx == i_count) active <= 1'b0;
            end
        end
    end

    // stored rows must have been written by a load or a vmacc first
    a_row_defined: assert property (@(posedge clk) disable iff (i_reset)
        (o_req && i_grant) |-> !$isunknown(i_row));

endmodule

`default_nettype wire

/* mem_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

`include "vlane_macros.svh"

module mem_arbiter (
    input  logic                    clk,
    input  logic                    i_reset,
    input  logic                    i_load_req,
    input  logic [`VL_MEM_AW-1:0]   i_load_addr,
    input  logic                    i_store_req,
    input  logic [`VL_MEM_AW-1:0]   i_store_addr,
    input  vlane_mem_pkg::row_t     i_store_row,
    input  logic                    i_mem_credit,
    output logic                    o_load_grant,
    output logic                    o_store_grant,
    output logic                    o_mem_req_valid,
    output vlane_mem_pkg::mem_req_t o_mem_req
);

    localparam int CW = $clog2(`VL_MEM_CREDITS + 1);

    logic [CW-1:0] credits;
    logic          have_credit;

    assign have_credit     = (credits != '0);
    assign o_load_grant    = i_load_req && have_credit; // load first
    assign o_store_grant   = i_store_req && have_credit && !i_load_req;
    assign o_mem_req_valid = o_load_grant || o_store_grant;

    always_comb begin
        o_mem_req.we    = !i_load_req;
        o_mem_req.addr  = i_load_req ? i_load_addr : i_store_addr;
        o_mem_req.wdata = i_store_row;
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            credits <= CW'(`VL_MEM_CREDITS);
        end else begin
            case ({o_mem_req_valid, i_mem_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits; // spent and returned together
            endcase
        end
    end

    // memory never returns more credits than it was given
    a_credit_bound: assert property (@(posedge clk) disable iff (i_reset)
        credits <= CW'(`VL_MEM_CREDITS));

endmodule

`default_nettype wire

/* vector_lane_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "vlane_macros.svh"

module vector_lane_top (
    input  logic                    clk,
    input  logic                    i_reset,
    input  logic                    i_instr_valid,
    input  vlane_isa_pkg::instr_u   i_instr,
    input  logic                    i_stream_valid,
    input  vlane_mem_pkg::row_t     i_stream_row,
    input  logic                    i_mem_credit,
    input  logic                    i_mem_rsp_valid,
    input  vlane_mem_pkg::row_t     i_mem_rsp_data,
    output logic                    o_instr_credit,
    output logic                    o_stream_credit,
    output logic                    o_mem_req_valid,
    output vlane_mem_pkg::mem_req_t o_mem_req
);

    logic                  load_start, store_start, mac_start;
    logic                  load_done, store_done, mac_done;
    logic [`VL_REG_AW-1:0] seq_vreg, seq_vs, seq_count;
    logic [`VL_MEM_AW-1:0] seq_mem_addr, load_addr, store_addr;
    logic                  fifo_empty, mac_pop;
    logic                  load_req, load_grant, store_req, store_grant;
    logic [`VL_REG_AW-1:0] rs_addr, rd_addr, st_raddr;
    vlane_mem_pkg::row_t   fifo_row, rs_row, rd_row, st_row;
    vlane_mem_pkg::rf_wr_t load_wr, mac_wr;

    vlane_sequencer vlane_sequencer_inst (
        .clk(clk), .i_reset(i_reset),
        .i_instr_valid(i_instr_valid), .i_instr(i_instr),
        .i_load_done(load_done), .i_store_done(store_done), .i_mac_done(mac_done),
        .o_instr_credit(o_instr_credit),
        .o_load_start(load_start), .o_store_start(store_start), .o_mac_start(mac_start),
        .o_vreg(seq_vreg), .o_vs(seq_vs), .o_mem_addr(seq_mem_addr), .o_count(seq_count)
    );

    stream_fifo stream_fifo_inst (
        .clk(clk), .i_reset(i_reset),
        .i_push(i_stream_valid), .i_push_row(i_stream_row), .i_pop(mac_pop),
        .o_row(fifo_row), .o_empty(fifo_empty), .o_credit(o_stream_credit)
    );

    // port a/b feed vmacc, port c feeds the store path
    vector_regfile vector_regfile_inst (
        .clk(clk),
        .i_raddr_a(rs_addr), .i_raddr_b(rd_addr), .i_raddr_c(st_raddr),
        .i_wr_load(load_wr), .i_wr_mac(mac_wr),
        .o_rdata_a(rs_row), .o_rdata_b(rd_row), .o_rdata_c(st_row)
    );

    vmacc_unit vmacc_unit_inst (
        .clk(clk), .i_reset(i_reset), .i_start(mac_start),
        .i_vd(seq_vreg), .i_vs(seq_vs), .i_count(seq_count),
        .i_fifo_empty(fifo_empty), .i_stream_row(fifo_row),
        .i_rs_row(rs_row), .i_rd_row(rd_row),
        .o_pop(mac_pop), .o_rs_addr(rs_addr), .o_rd_addr(rd_addr),
        .o_wr(mac_wr), .o_done(mac_done)
    );

    mem_load_engine mem_load_engine_inst (
        .clk(clk), .i_reset(i_reset), .i_start(load_start),
        .i_vreg(seq_vreg), .i_mem_addr(seq_mem_addr), .i_count(seq_count),
        .i_grant(load_grant), .i_rsp_valid(i_mem_rsp_valid), .i_rsp_data(i_mem_rsp_data),
        .o_req(load_req), .o_req_addr(load_addr), .o_wr(load_wr), .o_done(load_done)
    );

    mem_store_engine mem_store_engine_inst (
        .clk(clk), .i_reset(i_reset), .i_start(store_start),
        .i_vreg(seq_vreg), .i_mem_addr(seq_mem_addr), .i_count(seq_count),
        .i_grant(store_grant), .i_row(st_row),
        .o_req(store_req), .o_req_addr(store_addr), .o_raddr(st_raddr), .o_done(store_done)
    );

    mem_arbiter mem_arbiter_inst (
        .clk(clk), .i_reset(i_reset),
        .i_load_req(load_req), .i_load_addr(load_addr),
        .i_store_req(store_req), .i_store_addr(store_addr), .i_store_row(st_row),
        .i_mem_credit(i_mem_credit),
        .o_load_grant(load_grant), .o_store_grant(store_grant),
        .o_mem_req_valid(o_mem_req_valid), .o_mem_req(o_mem_req)
    );

endmodule

`default_nettype wire

/* tb_vector_lane.sv */
`timescale 1ns/10ps
`default_nettype none

`include "vlane_macros.svh"

module tb_vector_lane;

    localparam int TIMEOUT  = 2000; // cycles allowed per wait
    localparam int ROWS     = 8;    // rows per instruction
    localparam int MEM_ROWS = 64;

    logic                    clk;
    logic                    i_reset;
    logic                    i_instr_valid;
    vlane_isa_pkg::instr_u   i_instr;
    logic                    i_stream_valid;
    vlane_mem_pkg::row_t     i_stream_row;
    logic                    i_mem_credit;
    logic                    i_mem_rsp_valid;
    vlane_mem_pkg::row_t     i_mem_rsp_data;
    logic                    o_instr_credit;
    logic                    o_stream_credit;
    logic                    o_mem_req_valid;
    vlane_mem_pkg::mem_req_t o_mem_req;

    vlane_mem_pkg::row_t mem_model [MEM_ROWS];
    vlane_mem_pkg::row_t stream_sent [ROWS];
    vlane_mem_pkg::row_t stream_q [$];   // rows waiting for a stream credit
    logic [5:0]          read_q [$];     // reads not yet answered
    logic [31:0]         lfsr;
    int                  mem_credits, instr_credits, stream_credits, pending_credits;
    int                  instrs_sent, instr_pulses, rows_sent, stream_pulses;
    logic                quiet_check;

    vector_lane_top dut (
        .clk(clk), .i_reset(i_reset),
        .i_instr_valid(i_instr_valid), .i_instr(i_instr),
        .i_stream_valid(i_stream_valid), .i_stream_row(i_stream_row),
        .i_mem_credit(i_mem_credit),
        .i_mem_rsp_valid(i_mem_rsp_valid), .i_mem_rsp_data(i_mem_rsp_data),
        .o_instr_credit(o_instr_credit), .o_stream_credit(o_stream_credit),
        .o_mem_req_valid(o_mem_req_valid), .o_mem_req(o_mem_req)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // galois lfsr, one step per bit taken
    function automatic logic next_bit();
        logic b;
        b    = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) lfsr = lfsr ^ 32'hB4BCD35C;
        return b;
    endfunction

    function automatic logic [31:0] rand_word();
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < 32; i++) w = {w[30:0], next_bit()};
        return w;
    endfunction

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    function automatic vlane_isa_pkg::instr_u mem_op(input vlane_isa_pkg::opcode_e op,
                                                     input int vreg, input int addr);
        vlane_isa_pkg::instr_u ins;
        ins              = '0;
        ins.mem.opcode   = op;
        ins.mem.vreg     = `VL_REG_AW'(vreg);
        ins.mem.count    = `VL_REG_AW'(ROWS - 1);
        ins.mem.mem_addr = `VL_MEM_AW'(addr);
        return ins;
    endfunction

    function automatic vlane_isa_pkg::instr_u mac_op(input int vd, input int vs);
        vlane_isa_pkg::instr_u ins;
        ins              = '0;
        ins.arith.opcode = vlane_isa_pkg::OP_VMACC;
        ins.arith.vd     = `VL_REG_AW'(vd);
        ins.arith.vs     = `VL_REG_AW'(vs);
        ins.arith.count  = `VL_REG_AW'(ROWS - 1);
        return ins;
    endfunction

    // send one instruction, then hold until its credit is back
    task automatic run_instr(input vlane_isa_pkg::instr_u ins);
        int waited;
        waited = 0;
        @(posedge clk);
        i_instr_valid <= 1'b1;
        i_instr       <= ins;
        instrs_sent++;
        @(posedge clk);
        i_instr_valid <= 1'b0;
        do begin
            @(posedge clk);
            waited++;
            if (waited > TIMEOUT) stop_on_error("timeout waiting for the instruction credit");
        end while (instr_credits == 0);
    endtask

    task automatic check_row(input int addr, input vlane_mem_pkg::row_t exp);
        a_row_value: assert (mem_model[addr] == exp)
            else stop_on_error($sformatf("MISMATCH at %0t: mem_model[%0d] expected %h got %h",
                                         $time, addr, exp, mem_model[addr]));
    endtask

    always @(posedge clk) begin
        if (i_reset) begin
            mem_credits   <= `VL_MEM_CREDITS;
            instr_credits <= 1;
        end else begin
            mem_credits   <= mem_credits - int'(o_mem_req_valid) + int'(i_mem_credit);
            instr_credits <= instr_credits - int'(i_instr_valid) + int'(o_instr_credit);
            instr_pulses  <= instr_pulses + int'(o_instr_credit);
            stream_pulses <= stream_pulses + int'(o_stream_credit);
        end
    end

    // stream sender, one credit per row
    always @(posedge clk) begin
        if (!i_reset && stream_q.size() != 0 && stream_credits != 0) begin
            i_stream_valid <= 1'b1;
            i_stream_row   <= stream_q.pop_front();
            stream_credits <= stream_credits - 1 + int'(o_stream_credit);
            rows_sent      <= rows_sent + 1;
        end else begin
            i_stream_valid <= 1'b0;
            stream_credits <= i_reset ? `VL_STREAM_DEPTH : stream_credits + int'(o_stream_credit);
        end
    end

    // memory model, in-order reads and late credit return
    always @(posedge clk) begin
        if (!i_reset && o_mem_req_valid) begin
            if (o_mem_req.we) mem_model[o_mem_req.addr[5:0]] = o_mem_req.wdata;
            else read_q.push_back(o_mem_req.addr[5:0]);
            pending_credits++;
        end
        if (read_q.size() != 0 && next_bit()) begin
            i_mem_rsp_valid <= 1'b1;
            i_mem_rsp_data  <= mem_model[read_q.pop_front()];
        end else begin
            i_mem_rsp_valid <= 1'b0;
        end
        if (pending_credits != 0 && next_bit() && next_bit()) begin // about one in four
            i_mem_credit <= 1'b1;
            pending_credits--;
        end else begin
            i_mem_credit <= 1'b0;
        end
    end

    a_quiet_reset: assert property (@(posedge clk) quiet_check |->
        !(o_instr_credit || o_stream_credit || o_mem_req_valid))
        else stop_on_error($sformatf("MISMATCH at %0t: %s expected 000 got %b", $time,
            "o_instr_credit,o_stream_credit,o_mem_req_valid",
            $sampled({o_instr_credit, o_stream_credit, o_mem_req_valid})));

    a_req_credit: assert property (@(posedge clk) disable iff (i_reset)
        o_mem_req_valid |-> mem_credits > 0)
        else stop_on_error("memory request raised while no memory credit was left");

    a_instr_credit: assert property (@(posedge clk) disable iff (i_reset)
        o_instr_credit |-> instr_credits == 0)
        else stop_on_error("o_instr_credit returned with no instruction outstanding");

    a_stream_credit: assert property (@(posedge clk) disable iff (i_reset)
        o_stream_credit |-> stream_credits < `VL_STREAM_DEPTH)
        else stop_on_error("o_stream_credit returned more credits than rows were sent");

    initial begin
        vlane_mem_pkg::row_t exp;
        lfsr            = 32'd87;
        i_reset         = 1'b1;
        i_instr_valid   = 1'b0;
        i_instr         = '0;
        i_stream_valid  = 1'b0;
        i_stream_row    = '0;
        i_mem_credit    = 1'b0;
        i_mem_rsp_valid = 1'b0;
        i_mem_rsp_data  = '0;
        quiet_check     = 1'b0;
        pending_credits = 0;
        instrs_sent     = 0;
        instr_pulses    = 0;
        rows_sent       = 0;
        stream_pulses   = 0;
        for (int a = 0; a < MEM_ROWS; a++)
            for (int l = 0; l < `VL_LANES; l++) mem_model[a][l] = rand_word();
        // stream rows for the vmacc wait in the fifo from reset on
        for (int k = 0; k < ROWS; k++) begin
            for (int l = 0; l < `VL_LANES; l++) stream_sent[k][l] = rand_word();
            stream_q.push_back(stream_sent[k]);
        end
        @(posedge clk);
        quiet_check <= 1'b1; // outputs are defined from the first reset edge on
        repeat (15) @(posedge clk);
        i_reset <= 1'b0;
        repeat (4) @(posedge clk);
        quiet_check <= 1'b0;

        // copy mem 0..7 to mem 16..23 through v0..v7
        run_instr(mem_op(vlane_isa_pkg::OP_VLOAD, 0, 0));
        run_instr(mem_op(vlane_isa_pkg::OP_VSTORE, 0, 16));
        for (int k = 0; k < ROWS; k++) check_row(16 + k, mem_model[k]);

        // v8..v15 as multiplier, v0..v7 still hold mem 0..7
        run_instr(mem_op(vlane_isa_pkg::OP_VLOAD, 8, ROWS));
        run_instr(mac_op(0, 8));
        run_instr(mem_op(vlane_isa_pkg::OP_VSTORE, 0, 32));
        for (int k = 0; k < ROWS; k++) begin
            for (int l = 0; l < `VL_LANES; l++)
                exp[l] = mem_model[k][l] + stream_sent[k][l] * mem_model[ROWS + k][l];
            check_row(32 + k, exp);
        end

        a_instr_count: assert (instr_pulses == instrs_sent)
            else stop_on_error($sformatf(
                "MISMATCH at %0t: o_instr_credit pulses expected %0d got %0d",
                $time, instrs_sent, instr_pulses));
        a_stream_count: assert (stream_pulses == rows_sent)
            else stop_on_error($sformatf(
                "MISMATCH at %0t: o_stream_credit pulses expected %0d got %0d",
                $time, rows_sent, stream_pulses));
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+.
vlane_isa_pkg.sv
vlane_mem_pkg.sv
stream_fifo.sv
vector_regfile.sv
vlane_sequencer.sv
vmacc_unit.sv
mem_load_engine.sv
mem_store_engine.sv
mem_arbiter.sv
vector_lane_top.sv
tb_vector_lane.sv
